// ==== common/sv32_pkg.sv ====
package sv32_pkg;

    localparam int vpn_width    = 20;
    localparam int ppn_width    = 20;
    localparam int offset_width = 12;

    // Machine privilege encodings as seen on req_priv
    localparam logic [1:0] priv_u = 2'd0;
    localparam logic [1:0] priv_s = 2'd1;
    localparam logic [1:0] priv_m = 2'd3;

    // Sv32 page table entry, 32 bits
    typedef struct packed {
        logic [11:0] ppn1;  // Only [9:0] reach a 32-bit physical address
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    typedef struct packed {
        logic                 valid;
        logic [vpn_width-1:0] vpn;
        logic [ppn_width-1:0] ppn;
        logic                 g;
        logic                 u;
        logic                 w;
        logic                 r;
        logic                 d;
        logic                 a;
        logic                 level;  // Set for a 4 MB megapage
    } tlb_entry_t;

endpackage

// ==== mmu/mmu_tlb.sv ====
`timescale 1ns/1ps

module mmu_tlb
    import sv32_pkg::*;
#(
    parameter int tlb_entries = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] vaddr,
    input  logic        req_write,
    input  logic [1:0]  req_priv,
    input  logic        refill,
    input  pte_t        refill_pte,
    input  logic        refill_level,
    input  logic        tlb_flush,
    input  logic        tlb_flush_vaddr,
    input  logic [31:0] tlb_flush_addr,
    output logic        hit,
    output logic [31:0] hit_paddr,
    output logic        perm_ok
);

    localparam int idx_w = (tlb_entries > 1) ? $clog2(tlb_entries) : 1;

    tlb_entry_t             tlb_mem [tlb_entries];
    logic [idx_w-1:0]       rr_idx;
    logic [tlb_entries-1:0] match;
    tlb_entry_t             hit_entry;
    logic                   priv_ok;
    logic                   rw_ok;

    // Megapages compare only vpn1
    function automatic logic vpn_match(tlb_entry_t e, logic [vpn_width-1:0] vpn);
        if (e.level) begin
            return e.vpn[vpn_width-1:10] == vpn[vpn_width-1:10];
        end
        return e.vpn == vpn;
    endfunction

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            match[i] = tlb_mem[i].valid && vpn_match(tlb_mem[i], vaddr[31:offset_width]);
        end
    end

    // Walk down so the lowest matching index is the one left
    always_comb begin
        hit_entry = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_entry = tlb_mem[i];
            end
        end
    end

    assign hit = |match;

    always_comb begin
        if (hit_entry.level) begin
            hit_paddr = {hit_entry.ppn[ppn_width-1:10], vaddr[21:12],
                         vaddr[offset_width-1:0]};
        end else begin
            hit_paddr = {hit_entry.ppn, vaddr[offset_width-1:0]};
        end
    end

    always_comb begin
        case (req_priv)
            priv_m:  priv_ok = 1'b1;
            priv_s:  priv_ok = !hit_entry.u;
            default: priv_ok = hit_entry.u;  // priv_u
        endcase
        // A write to a clean page counts as a fault since D is not updated here
        rw_ok = req_write ? (hit_entry.w && hit_entry.d) : hit_entry.r;
    end

    assign perm_ok = priv_ok && rw_ok && hit_entry.a;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < tlb_entries; i++) begin
                tlb_mem[i].valid <= 1'b0;
            end
            rr_idx <= '0;
        end else begin
            if (refill) begin
                tlb_mem[rr_idx].valid <= 1'b1;
                tlb_mem[rr_idx].vpn   <= vaddr[31:offset_width];
                tlb_mem[rr_idx].ppn   <= {refill_pte.ppn1[9:0], refill_pte.ppn0};
                tlb_mem[rr_idx].g     <= refill_pte.g;
                tlb_mem[rr_idx].u     <= refill_pte.u;
                tlb_mem[rr_idx].w     <= refill_pte.w;
                tlb_mem[rr_idx].r     <= refill_pte.r;
                tlb_mem[rr_idx].d     <= refill_pte.d;
                tlb_mem[rr_idx].a     <= refill_pte.a;
                tlb_mem[rr_idx].level <= refill_level;
                if (rr_idx == idx_w'(tlb_entries - 1)) begin
                    rr_idx <= '0;
                end else begin
                    rr_idx <= rr_idx + 1'b1;
                end
            end
            if (tlb_flush) begin
                for (int i = 0; i < tlb_entries; i++) begin
                    if (!tlb_flush_vaddr ||
                        vpn_match(tlb_mem[i], tlb_flush_addr[31:offset_width])) begin
                        tlb_mem[i].valid <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== mmu/mmu_ptw.sv ====
`timescale 1ns/1ps

module mmu_ptw
    import sv32_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [31:0] vaddr,
    input  logic [31:0] satp,
    input  logic [31:0] ptw_data,
    input  logic        ptw_ready,
    output logic        ptw_req,
    output logic [31:0] ptw_addr,
    output logic        refill,
    output pte_t        refill_pte,
    output logic        refill_level,
    output logic        walk_fault
);

    typedef enum logic [2:0] {
        st_idle,
        st_l1,      // Issue root PTE read
        st_l0,      // Issue leaf table read
        st_wait,
        st_refill,
        st_fault
    } ptw_state_t;

    ptw_state_t state;
    ptw_state_t state_nxt;
    pte_t       pte_q;
    logic       pte_loaded;  // pte_q holds the answer to the last read
    logic       level_q;
    logic       is_ptr;

    assign is_ptr = pte_q.v && !pte_q.r && !pte_q.w && !pte_q.x;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:   if (start) state_nxt = st_l1;
            st_l1:     state_nxt = st_wait;
            st_l0:     state_nxt = st_wait;
            st_wait: begin
                if (pte_loaded) begin
                    if (!pte_q.v) begin
                        state_nxt = st_fault;
                    end else if (is_ptr) begin
                        // Pointer is only legal at the root level
                        state_nxt = level_q ? st_l0 : st_fault;
                    end else if (level_q && pte_q.ppn0 != '0) begin
                        state_nxt = st_fault;  // Misaligned megapage
                    end else begin
                        state_nxt = st_refill;
                    end
                end
            end
            st_refill: state_nxt = st_idle;
            st_fault:  state_nxt = st_idle;
            default:   state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            level_q    <= 1'b0;
            pte_loaded <= 1'b0;
        end else begin
            state      <= state_nxt;
            pte_loaded <= (state == st_wait) && ptw_ready;
            if (state == st_idle && start) begin
                level_q <= 1'b1;
            end else if (state == st_l0) begin
                level_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ptw_ready) begin
            pte_q <= ptw_data;
        end
    end

    // PTE addresses, 4 bytes per entry
    always_comb begin
        if (state == st_l0) begin
            ptw_addr = {pte_q.ppn1[9:0], pte_q.ppn0, 12'b0} + {20'b0, vaddr[21:12], 2'b00};
        end else begin
            ptw_addr = {satp[31:12], 12'b0} + {20'b0, vaddr[31:22], 2'b00};
        end
    end

    assign ptw_req      = (state == st_l1) || (state == st_l0);
    assign refill       = (state == st_refill);
    assign refill_pte   = pte_q;
    assign refill_level = level_q;
    assign walk_fault   = (state == st_fault);

endmodule

// ==== mmu/mmu.sv ====
`timescale 1ns/1ps

module mmu
    import sv32_pkg::*;
#(
    parameter int tlb_entries = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] vaddr,
    input  logic        req_valid,
    input  logic        req_write,
    input  logic [1:0]  req_priv,
    output logic [31:0] paddr,
    output logic        trans_valid,
    output logic        page_fault,
    output logic        access_fault,
    input  logic [31:0] satp,
    input  logic        vm_enable,
    output logic        ptw_req,
    output logic [31:0] ptw_addr,
    input  logic [31:0] ptw_data,
    input  logic        ptw_ready,
    input  logic        tlb_flush,
    input  logic        tlb_flush_vaddr,
    input  logic [31:0] tlb_flush_addr
);

    logic        hit;
    logic [31:0] hit_paddr;
    logic        perm_ok;
    logic        walk_start;
    logic        refill;
    pte_t        refill_pte;
    logic        refill_level;
    logic        walk_fault;

    // Walk only on a real translated miss
    assign walk_start = req_valid && vm_enable && !hit;

    mmu_tlb #(
        .tlb_entries (tlb_entries)
    ) u_tlb (
        .clk             (clk),
        .rst_n           (rst_n),
        .vaddr           (vaddr),
        .req_write       (req_write),
        .req_priv        (req_priv),
        .refill          (refill),
        .refill_pte      (refill_pte),
        .refill_level    (refill_level),
        .tlb_flush       (tlb_flush),
        .tlb_flush_vaddr (tlb_flush_vaddr),
        .tlb_flush_addr  (tlb_flush_addr),
        .hit             (hit),
        .hit_paddr       (hit_paddr),
        .perm_ok         (perm_ok)
    );

    mmu_ptw u_ptw (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (walk_start),
        .vaddr        (vaddr),
        .satp         (satp),
        .ptw_data     (ptw_data),
        .ptw_ready    (ptw_ready),
        .ptw_req      (ptw_req),
        .ptw_addr     (ptw_addr),
        .refill       (refill),
        .refill_pte   (refill_pte),
        .refill_level (refill_level),
        .walk_fault   (walk_fault)
    );

    always_comb begin
        if (!vm_enable) begin
            paddr        = vaddr;  // Bare mode
            trans_valid  = req_valid;
            page_fault   = 1'b0;
            access_fault = 1'b0;
        end else begin
            // Walked pages come back through the TLB and get checked the same way
            paddr        = hit_paddr;
            trans_valid  = req_valid && hit && perm_ok;
            access_fault = req_valid && hit && !perm_ok;
            page_fault   = walk_fault;
        end
    end

endmodule

// ==== hdl/pt_ram.sv ====
`timescale 1ns/1ps

module pt_ram #(
    parameter int pt_words    = 2048,
    parameter int mem_latency = 2
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_en,
    input  logic [$clog2(pt_words)-1:0] load_addr,
    input  logic [31:0]                 load_data,
    input  logic                        ptw_req,
    input  logic [31:0]                 ptw_addr,
    output logic [31:0]                 ptw_data,
    output logic                        ptw_ready
);

    localparam int addr_w = $clog2(pt_words);

    logic [31:0]            mem [pt_words];
    logic [31:0]            data_pipe [mem_latency];
    logic [mem_latency-1:0] rdy_pipe;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (ptw_req) begin
            data_pipe[0] <= mem[ptw_addr[addr_w+1:2]];  // Word index, upper bits dropped
        end
        for (int k = 1; k < mem_latency; k++) begin
            data_pipe[k] <= data_pipe[k-1];
        end
    end

    // Strobe travels alongside the word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_pipe <= '0;
        end else begin
            rdy_pipe[0] <= ptw_req;
            for (int k = 1; k < mem_latency; k++) begin
                rdy_pipe[k] <= rdy_pipe[k-1];
            end
        end
    end

    assign ptw_ready = rdy_pipe[mem_latency-1];
    assign ptw_data  = data_pipe[mem_latency-1];

endmodule

// ==== hdl/xlate_top.sv ====
`timescale 1ns/1ps

module xlate_top #(
    parameter int tlb_entries = 16,
    parameter int pt_words    = 2048,
    parameter int mem_latency = 2
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [31:0]                 vaddr,
    input  logic                        req_valid,
    input  logic                        req_write,
    input  logic [1:0]                  req_priv,
    input  logic [31:0]                 satp,
    input  logic                        vm_enable,
    input  logic                        tlb_flush,
    input  logic                        tlb_flush_vaddr,
    input  logic [31:0]                 tlb_flush_addr,
    input  logic                        load_en,
    input  logic [$clog2(pt_words)-1:0] load_addr,
    input  logic [31:0]                 load_data,
    output logic [31:0]                 paddr,
    output logic                        trans_valid,
    output logic                        page_fault,
    output logic                        access_fault
);

    logic        ptw_req;
    logic [31:0] ptw_addr;
    logic [31:0] ptw_data;
    logic        ptw_ready;

    mmu #(
        .tlb_entries (tlb_entries)
    ) u_mmu (
        .clk             (clk),
        .rst_n           (rst_n),
        .vaddr           (vaddr),
        .req_valid       (req_valid),
        .req_write       (req_write),
        .req_priv        (req_priv),
        .paddr           (paddr),
        .trans_valid     (trans_valid),
        .page_fault      (page_fault),
        .access_fault    (access_fault),
        .satp            (satp),
        .vm_enable       (vm_enable),
        .ptw_req         (ptw_req),
        .ptw_addr        (ptw_addr),
        .ptw_data        (ptw_data),
        .ptw_ready       (ptw_ready),
        .tlb_flush       (tlb_flush),
        .tlb_flush_vaddr (tlb_flush_vaddr),
        .tlb_flush_addr  (tlb_flush_addr)
    );

    // Page tables live here, filled by the load port
    pt_ram #(
        .pt_words    (pt_words),
        .mem_latency (mem_latency)
    ) u_pt_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .ptw_req   (ptw_req),
        .ptw_addr  (ptw_addr),
        .ptw_data  (ptw_data),
        .ptw_ready (ptw_ready)
    );

endmodule

// ==== dv/tb_xlate.sv ====
`timescale 1ns/1ps

module tb_xlate
    import sv32_pkg::*;
();

    localparam int tlb_entries = 16;
    localparam int pt_words    = 2048;
    localparam int mem_latency = 2;
    localparam int cycle_limit = 200 * (mem_latency + 10) + 1000;
    localparam int req_limit   = 4 * mem_latency + 20;  // Two PTE reads plus FSM overhead
    localparam int l0_base     = 1024;                  // Level 0 table sits in page 1

    localparam logic [1:0] res_none = 2'd0;
    localparam logic [1:0] res_ok   = 2'd1;
    localparam logic [1:0] res_pf   = 2'd2;
    localparam logic [1:0] res_af   = 2'd3;

    logic                        clk;
    logic                        rst_n;
    logic [31:0]                 vaddr;
    logic                        req_valid;
    logic                        req_write;
    logic [1:0]                  req_priv;
    logic [31:0]                 satp;
    logic                        vm_enable;
    logic                        tlb_flush;
    logic                        tlb_flush_vaddr;
    logic [31:0]                 tlb_flush_addr;
    logic                        load_en;
    logic [$clog2(pt_words)-1:0] load_addr;
    logic [31:0]                 load_data;
    logic [31:0]                 paddr;
    logic                        trans_valid;
    logic                        page_fault;
    logic                        access_fault;

    logic [31:0] pt [pt_words];  // Copy of what was loaded into the RAM
    logic [1:0]  privs [3] = '{priv_u, priv_s, priv_m};
    integer      seed = 75;
    int          cycles;
    int          checks;
    int          errors;
    int          mark_checks;
    int          mark_errors;

    xlate_top #(
        .tlb_entries (tlb_entries),
        .pt_words    (pt_words),
        .mem_latency (mem_latency)
    ) dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .vaddr           (vaddr),
        .req_valid       (req_valid),
        .req_write       (req_write),
        .req_priv        (req_priv),
        .satp            (satp),
        .vm_enable       (vm_enable),
        .tlb_flush       (tlb_flush),
        .tlb_flush_vaddr (tlb_flush_vaddr),
        .tlb_flush_addr  (tlb_flush_addr),
        .load_en         (load_en),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .paddr           (paddr),
        .trans_valid     (trans_valid),
        .page_fault      (page_fault),
        .access_fault    (access_fault)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing", cycles);
        $display("** FAIL **");
        $finish;
    end

    // Flags in fl are {u, r, w, a, d}
    function automatic pte_t leaf_pte(input logic [9:0] p1, input logic [9:0] p0,
                                      input logic [4:0] fl);
        pte_t p;
        p      = '0;
        p.ppn1 = {2'b00, p1};
        p.ppn0 = p0;
        {p.u, p.r, p.w, p.a, p.d} = fl;
        p.x    = 1'b1;  // Keeps it a leaf even with r and w clear
        p.v    = 1'b1;
        return p;
    endfunction

    function automatic pte_t pointer_pte(input logic [9:0] p0);
        pte_t p;
        p      = '0;
        p.ppn0 = p0;
        p.v    = 1'b1;
        return p;
    endfunction

    // Reference Sv32 walk over the copy followed by the permission rule
    function automatic void ref_walk(input logic [31:0] va, input logic wr,
                                     input logic [1:0] pv, output logic [1:0] kind,
                                     output logic [31:0] pa);
        pte_t        pte;
        logic        mega;
        logic        ok;
        logic [31:0] a;
        mega = 1'b1;
        a    = {satp[31:12], 12'h000} + {20'h0, va[31:22], 2'b00};
        pte  = pt[a[12:2]];
        if (pte.v && !(pte.r || pte.w || pte.x)) begin
            a    = {pte.ppn1[9:0], pte.ppn0, 12'h000} + {20'h0, va[21:12], 2'b00};
            pte  = pt[a[12:2]];
            mega = 1'b0;
        end
        kind = res_pf;
        pa   = va;
        if (!pte.v || !(pte.r || pte.w || pte.x) || (mega && pte.ppn0 != 10'h0)) begin
            return;
        end
        ok = pte.a && (wr ? (pte.w && pte.d) : pte.r);
        if (pv == priv_s && pte.u) ok = 1'b0;  // Supervisor kept off user pages
        if (pv == priv_u && !pte.u) ok = 1'b0;
        kind = ok ? res_ok : res_af;
        pa   = mega ? {pte.ppn1[9:0], va[21:0]} : {pte.ppn1[9:0], pte.ppn0, va[11:0]};
    endfunction

    task automatic write_pte(input int idx, input pte_t p);
        pt[idx] = p;
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = idx[10:0];
        load_data = p;
        @(negedge clk);
        load_en   = 1'b0;
    endtask

    task automatic pulse_flush(input logic by_addr, input logic [31:0] addr);
        @(negedge clk);
        tlb_flush       = 1'b1;
        tlb_flush_vaddr = by_addr;
        tlb_flush_addr  = addr;
        @(negedge clk);
        tlb_flush       = 1'b0;
    endtask

    // Holds the request until a result shows and counts the clock edges waited in lat
    task automatic do_req(input logic [31:0] va, input logic wr, input logic [1:0] pv,
                          output logic [1:0] kind, output logic [31:0] pa, output int lat);
        @(negedge clk);
        vaddr     = va;
        req_write = wr;
        req_priv  = pv;
        req_valid = 1'b1;
        kind      = res_none;
        pa        = '0;
        lat       = 0;
        while (kind == res_none && lat <= req_limit) begin
            #1;  // Mid low phase
            if (int'(trans_valid) + int'(page_fault) + int'(access_fault) > 1) begin
                $display("ERR %0t: more than one result high for vaddr %h", $time, va);
                errors++;
            end
            if (trans_valid) kind = res_ok;
            else if (page_fault) kind = res_pf;
            else if (access_fault) kind = res_af;
            pa = paddr;
            if (kind == res_none) begin
                @(negedge clk);
                lat++;
            end
        end
        if (kind == res_none) begin
            $display("Timeout: no result for vaddr %h after %0d cycles", va, lat);
            errors++;
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic check_result(input logic [31:0] va, input logic wr, input logic [1:0] pv,
                                input logic [1:0] ekind, input logic [31:0] epa,
                                input bit want_hit);
        logic [1:0]  kind;
        logic [31:0] pa;
        int          lat;
        do_req(va, wr, pv, kind, pa, lat);
        checks++;
        if (kind != res_none && kind != ekind) begin
            $display("ERR %0t: vaddr %h priv %0d write %0b gave result %0d, expected %0d",
                     $time, va, pv, wr, kind, ekind);
            errors++;
        end else if (kind != res_none && ekind != res_pf && pa !== epa) begin
            $display("ERR %0t: vaddr %h gave paddr %h, expected %h", $time, va, pa, epa);
            errors++;
        end
        if (want_hit && kind != res_none && lat != 0) begin
            $display("ERR %0t: vaddr %h took %0d cycles, expected a same-cycle hit",
                     $time, va, lat);
            errors++;
        end
    endtask

    task automatic check_model(input logic [31:0] va, input logic wr, input logic [1:0] pv,
                               input bit want_hit, output logic [1:0] ekind);
        logic [31:0] epa;
        ref_walk(va, wr, pv, ekind, epa);
        check_result(va, wr, pv, ekind, epa, want_hit);
    endtask

    task automatic build_tables;
        logic [31:0] r;
        write_pte(0, pointer_pte(10'd1));
        for (int i = 1; i < 16; i++) begin
            r = $random(seed);
            if (i == 12) begin
                write_pte(i, '0);
            end else if (i == 13) begin
                write_pte(i, leaf_pte(10'h10d, 10'h005, 5'b01111));  // Misaligned megapage
            end else begin
                write_pte(i, leaf_pte(10'h100 + 10'(i), 10'h0, {r[4:2], 1'b1, r[5]}));
            end
        end
        // Every {u, r, w, a, d} combination as a megapage
        for (int i = 0; i < 32; i++) begin
            write_pte(16 + i, leaf_pte(10'h200 + 10'(i), 10'h0, 5'(i)));
        end
        for (int j = 0; j < 32; j++) begin
            r = $random(seed);
            if (j == 28) begin
                write_pte(l0_base + j, pointer_pte(10'd1));  // Pointer where a leaf belongs
            end else if (j == 29) begin
                write_pte(l0_base + j, '0);
            end else begin
                write_pte(l0_base + j, leaf_pte(r[31:22], r[21:12], {r[4:2], 1'b1, r[5]}));
            end
        end
    endtask

    task automatic begin_test;
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
    endtask

    initial begin
        logic [31:0] va;
        logic [31:0] r;
        logic [1:0]  kind;
        logic [1:0]  pv;
        logic [31:0] fva [3];
        logic [1:0]  old_kind [3];
        logic [31:0] old_pa [3];
        rst_n           = 1'b0;
        vaddr           = '0;
        req_valid       = 1'b0;
        req_write       = 1'b0;
        req_priv        = priv_m;
        satp            = '0;  // Root table in page 0
        vm_enable       = 1'b0;
        tlb_flush       = 1'b0;
        tlb_flush_vaddr = 1'b0;
        tlb_flush_addr  = '0;
        load_en         = 1'b0;
        load_addr       = '0;
        load_data       = '0;
        checks          = 0;
        errors          = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        build_tables();

        begin_test();
        for (int i = 0; i < 10; i++) begin
            r  = $random(seed);
            va = $random(seed);
            check_result(va, r[0], privs[r[2:1] % 3], res_ok, va, 1'b1);
        end
        end_test("bypass");

        @(negedge clk);
        vm_enable = 1'b1;
        begin_test();
        for (int i = 0; i < 80; i++) begin
            r         = $random(seed);
            va        = $random(seed);
            va[31:22] = {6'd0, r[3:0]};
            if (r[3:0] == 4'd0) va[21:17] = 5'd0;  // Stay in the loaded part of page 1
            pv = privs[r[5:4] % 3];
            check_model(va, r[6], pv, 1'b0, kind);
            if (kind != res_pf) begin
                va[11:0] = r[19:8];
                check_model(va, r[6], pv, 1'b1, kind);
            end
        end
        end_test("translate");

        begin_test();
        for (int i = 0; i < 32; i++) begin
            va        = $random(seed);
            va[31:22] = 10'd16 + 10'(i);
            for (int p = 0; p < 3; p++) begin
                for (int w = 0; w < 2; w++) begin
                    check_model(va, w[0], privs[p], (p + w) != 0, kind);
                end
            end
        end
        end_test("permission");

        begin_test();
        check_result({10'd12, 22'h15a5a}, 1'b0, priv_m, res_pf, 32'h0, 1'b0);
        check_result({10'd13, 22'h2f00f}, 1'b0, priv_m, res_pf, 32'h0, 1'b0);
        check_result({10'd0, 10'd28, 12'h44c}, 1'b0, priv_s, res_pf, 32'h0, 1'b0);
        check_result({10'd0, 10'd29, 12'h010}, 1'b1, priv_u, res_pf, 32'h0, 1'b0);
        end_test("walk fault");

        begin_test();
        fva[0] = {10'd0, 10'd30, 12'h123};
        fva[1] = {10'd0, 10'd31, 12'h456};
        fva[2] = {10'd14, 22'h0789a};
        pulse_flush(1'b0, 32'h0);  // Three fresh refills land in adjacent slots
        for (int k = 0; k < 3; k++) begin
            ref_walk(fva[k], 1'b0, priv_m, old_kind[k], old_pa[k]);
            check_model(fva[k], 1'b0, priv_m, 1'b0, kind);
        end
        write_pte(l0_base + 30, leaf_pte(10'h3a1, 10'h0f0, 5'b01111));
        write_pte(l0_base + 31, leaf_pte(10'h3a2, 10'h0f1, 5'b01111));
        write_pte(14, leaf_pte(10'h3a3, 10'h0, 5'b01111));
        pulse_flush(1'b1, fva[0]);
        check_model(fva[0], 1'b0, priv_m, 1'b0, kind);
        check_result(fva[1], 1'b0, priv_m, old_kind[1], old_pa[1], 1'b1);  // Stale but cached
        check_result(fva[2], 1'b0, priv_m, old_kind[2], old_pa[2], 1'b1);
        pulse_flush(1'b0, 32'h0);
        for (int k = 0; k < 3; k++) begin
            check_model(fva[k], 1'b0, priv_m, 1'b0, kind);
        end
        end_test("flush");

        begin_test();
        for (int pass = 0; pass < 2; pass++) begin
            for (int k = 0; k < tlb_entries + 4; k++) begin
                va = {10'd0, 10'(k), 12'(k * 36)};
                check_model(va, 1'b0, priv_m, 1'b0, kind);
            end
        end
        end_test("refill wrap");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/sv32_pkg.sv
mmu/mmu_tlb.sv
mmu/mmu_ptw.sv
mmu/mmu.sv
hdl/pt_ram.sv
hdl/xlate_top.sv
dv/tb_xlate.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_xlate -f tb.f -o sim_tb_xlate

out=$(./obj_dir/sim_tb_xlate)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
